// ==== design/soc_pkg.sv ====
// SoC bus control shared definitions
// Bus widths, slave numbering, address windows and interrupt vectors

package soc_pkg;

  // --------------------------------------------------
  // Bus widths
  // --------------------------------------------------
  localparam int DATA_W     = 16;               // CPU data bus
  localparam int ADDR_W     = 20;               // Tag bit + word address 19:1
  localparam int SEL_W      = DATA_W / 8;       // Byte lanes
  localparam int NUM_SLAVES = 5;                // Decoded slaves, default not counted
  localparam int NUM_IRQ    = 8;
  localparam int IID_W      = $clog2(NUM_IRQ);

  // Slave index into the strobe and ack vectors
  typedef enum logic [2:0] {
    SLV_ROM   = 3'd0,
    SLV_VGA   = 3'd1,
    SLV_UART  = 3'd2,
    SLV_TIMER = 3'd3,
    SLV_RAM   = 3'd4
  } slave_e;

  // One address word, seen as memory or as I/O space
  typedef union packed {
    struct packed {
      logic        tag;                         // 0 for memory
      logic [18:0] wadr;                        // Word address 19:1
    } mem;
    struct packed {
      logic        tag;                         // 1 for I/O
      logic [3:0]  rsvd;                        // Upper bits, not decoded
      logic [14:0] port;                        // Port address 15:1
    } io;
  } bus_addr_u;

  // --------------------------------------------------
  // Address windows, base and mask
  // --------------------------------------------------
  localparam bus_addr_u ROM_BASE     = 20'b0_1111_1111_1111_0000_000; // 0xFFF00
  localparam bus_addr_u ROM_MASK     = 20'b1_1111_1111_1111_0000_000;
  localparam bus_addr_u VGA_MEM_BASE = 20'b0_1010_0000_0000_0000_000; // 0xA0000
  localparam bus_addr_u VGA_MEM_MASK = 20'b1_1110_0000_0000_0000_000;
  localparam bus_addr_u VGA_IO_BASE  = 20'b1_0000_0000_0011_1100_000; // io 0x3C0
  localparam bus_addr_u VGA_IO_MASK  = 20'b1_0000_1111_1111_1110_000;
  localparam bus_addr_u UART_BASE    = 20'b1_0000_0000_0011_1111_100; // io 0x3F8
  localparam bus_addr_u UART_MASK    = 20'b1_0000_1111_1111_1111_100;
  localparam bus_addr_u TIMER_BASE   = 20'b1_0000_0000_0000_0100_000; // io 0x40
  localparam bus_addr_u TIMER_MASK   = 20'b1_0000_1111_1111_1111_110;
  localparam bus_addr_u RAM_BASE     = 20'b0_0000_0000_0000_0000_000; // Any memory
  localparam bus_addr_u RAM_MASK     = 20'b1_0000_0000_0000_0000_000;

  // Acknowledge cycle vectors
  localparam logic [DATA_W-1:0] NMI_VECTOR      = 16'h0002;
  localparam logic [DATA_W-1:0] IRQ_VECTOR_BASE = 16'h0008;

endpackage

// ==== design/cpu_bus_if.sv ====
// CPU request bundle
// Carries one bus cycle from the top level to the slave decoder

`timescale 1ns/1ps

interface cpu_bus_if;
  import soc_pkg::*;

  bus_addr_u          adr;    // Tag + word address
  logic [DATA_W-1:0]  dat_w;  // Write data
  logic [SEL_W-1:0]   sel;    // Byte lanes
  logic               we;
  logic               cyc;
  logic               stb;

  // Driven from the CPU ports
  modport source (
    output adr,
    output dat_w,
    output sel,
    output we,
    output cyc,
    output stb
  );

  // Decode needs address and cycle qualifiers only
  modport decoder (
    input adr,
    input cyc,
    input stb
  );

endinterface

// ==== design/reset_debounce.sv ====
// Power-on reset debounce
// Stretches any low pulse on rst_lck into a full-length system reset

`timescale 1ns/1ps

module reset_debounce #(
  parameter int unsigned DEBOUNCE_CYCLES = 131071
) (
  input  logic clk,
  input  logic rst_lck,     // Active low, may bounce
  output logic sys_rst_o    // Active high, clean
);

  localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

  logic [CNT_W-1:0] cnt_q;
  logic             rst_q;

  // Reload while held, count out after release
  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      cnt_q <= CNT_W'(DEBOUNCE_CYCLES);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Registered output, high from the first low sample
  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      rst_q <= 1'b1;
    end else begin
      rst_q <= (cnt_q != '0);   // Drops once the count is spent
    end
  end

  assign sys_rst_o = rst_q;

endmodule

// ==== design/slave_decoder.sv ====
// Slave decoder
// Address/mask match of each CPU cycle, one-hot strobe, read data and
// ack return, plus a default slave that acks unmapped I/O with zero

`timescale 1ns/1ps

module slave_decoder (
  input  logic                                  clk,
  input  logic                                  sys_rst_i,
  cpu_bus_if.decoder                            bus,
  output logic [soc_pkg::NUM_SLAVES-1:0]        slv_stb_o,
  input  logic [soc_pkg::NUM_SLAVES-1:0]        slv_ack_i,
  input  logic [soc_pkg::DATA_W-1:0]            slv_dat_i [soc_pkg::NUM_SLAVES],
  output logic [soc_pkg::DATA_W-1:0]            rd_dat_o,
  output logic                                  ack_o
);
  import soc_pkg::*;

  // --------------------------------------------------
  // Window match in memory and I/O view
  // --------------------------------------------------
  function automatic logic mem_hit(bus_addr_u a, bus_addr_u base, bus_addr_u mask);
    return ((a.mem.tag & mask.mem.tag) == base.mem.tag) &&
           ((a.mem.wadr & mask.mem.wadr) == base.mem.wadr);
  endfunction

  function automatic logic io_hit(bus_addr_u a, bus_addr_u base, bus_addr_u mask);
    return a.io.tag && ((a.io.port & mask.io.port) == base.io.port);
  endfunction

  logic   cyc_act;    // Live cycle outside reset
  logic   dec_hit;    // Some window matched
  slave_e dec_idx;
  logic   busy_q;     // Cycle waiting on a slave ack
  logic   hit_q;
  slave_e idx_q;
  logic   cur_hit;
  slave_e cur_idx;

  assign cyc_act = bus.cyc && bus.stb && !sys_rst_i;

  // Fixed priority with RAM checked last
  always_comb begin
    dec_hit = 1'b1;
    dec_idx = SLV_RAM;
    if (mem_hit(bus.adr, ROM_BASE, ROM_MASK)) begin
      dec_idx = SLV_ROM;                              // Boot ROM overlays RAM
    end else if (mem_hit(bus.adr, VGA_MEM_BASE, VGA_MEM_MASK) ||
                 io_hit(bus.adr, VGA_IO_BASE, VGA_IO_MASK)) begin
      dec_idx = SLV_VGA;
    end else if (io_hit(bus.adr, UART_BASE, UART_MASK)) begin
      dec_idx = SLV_UART;
    end else if (io_hit(bus.adr, TIMER_BASE, TIMER_MASK)) begin
      dec_idx = SLV_TIMER;
    end else if (mem_hit(bus.adr, RAM_BASE, RAM_MASK)) begin
      dec_idx = SLV_RAM;                              // Memory space only
    end else begin
      dec_hit = 1'b0;                                 // Default slave
    end
  end

  // --------------------------------------------------
  // Selection hold while a slave stretches its ack
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (sys_rst_i) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= cyc_act && !ack_o;   // Clears on ack or a dropped cycle
    end
  end

  // Capture the decode of the first cycle
  always_ff @(posedge clk) begin
    if (!busy_q) begin
      hit_q <= dec_hit;
      idx_q <= dec_idx;
    end
  end

  assign cur_hit = busy_q ? hit_q : dec_hit;
  assign cur_idx = busy_q ? idx_q : dec_idx;

  // One-hot strobe with none for the default slave
  always_comb begin
    slv_stb_o = '0;
    if (cyc_act && cur_hit) begin
      slv_stb_o[cur_idx] = 1'b1;
    end
  end

  // Default slave acks at once
  assign ack_o    = cyc_act && (cur_hit ? slv_ack_i[cur_idx] : 1'b1);
  assign rd_dat_o = cur_hit ? slv_dat_i[cur_idx] : '0;   // Zero from default

endmodule

// ==== design/irq_controller.sv ====
// Priority interrupt controller
// Edge-detects eight request lines, keeps pending bits and reports
// the lowest pending index, cleared by the CPU acknowledge

`timescale 1ns/1ps

module irq_controller (
  input  logic                          clk,
  input  logic                          sys_rst_i,
  input  logic [soc_pkg::NUM_IRQ-1:0]   intv_i,
  input  logic                          inta_i,
  output logic                          intr_o,
  output logic [soc_pkg::IID_W-1:0]     iid_o
);
  import soc_pkg::*;

  logic [NUM_IRQ-1:0] intv_s_q;     // Sampled requests
  logic [NUM_IRQ-1:0] intv_p_q;     // Previous sample
  logic [NUM_IRQ-1:0] rise;
  logic [NUM_IRQ-1:0] clr;
  logic [NUM_IRQ-1:0] pending_q;
  logic [IID_W-1:0]   iid;

  // --------------------------------------------------
  // Edge detect
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (sys_rst_i) begin
      intv_s_q <= '0;
      intv_p_q <= '0;
    end else begin
      intv_s_q <= intv_i;
      intv_p_q <= intv_s_q;
    end
  end

  assign rise = intv_s_q & ~intv_p_q;   // One cycle per low-to-high

  // Lowest index wins
  always_comb begin
    iid = '0;
    for (int i = NUM_IRQ - 1; i >= 0; i--) begin
      if (pending_q[i]) begin
        iid = IID_W'(i);
      end
    end
  end

  // Acknowledge retires the reported line
  assign clr = (inta_i && (pending_q != '0)) ? (NUM_IRQ'(1) << iid) : '0;

  // --------------------------------------------------
  // Pending bits
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (sys_rst_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q & ~clr) | rise;   // New edge beats clear
    end
  end

  assign intr_o = |pending_q;
  assign iid_o  = iid;

endmodule

// ==== design/cpu_response_mux.sv ====
// CPU read data select
// NMI vector first, then interrupt vector, else switched slave data

`timescale 1ns/1ps

module cpu_response_mux (
  input  logic                        nmia_i,
  input  logic                        inta_i,
  input  logic [soc_pkg::IID_W-1:0]   iid_i,
  input  logic [soc_pkg::DATA_W-1:0]  rd_dat_i,
  output logic [soc_pkg::DATA_W-1:0]  cpu_dat_o
);
  import soc_pkg::*;

  logic [DATA_W-1:0] irq_vec;

  // Vector table entry per line
  assign irq_vec = IRQ_VECTOR_BASE + DATA_W'(iid_i);

  always_comb begin
    if (nmia_i) begin
      cpu_dat_o = NMI_VECTOR;     // Overrides a concurrent inta
    end else if (inta_i) begin
      cpu_dat_o = irq_vec;
    end else begin
      cpu_dat_o = rd_dat_i;       // Normal bus read
    end
  end

endmodule

// ==== design/soc_bus_ctrl.sv ====
// CPU bus fabric top level
// Reset debounce, slave decode, interrupt controller and the CPU
// read mux, wired between the CPU ports and the five slaves

`timescale 1ns/1ps

module soc_bus_ctrl #(
  parameter int unsigned DEBOUNCE_CYCLES = 131071
) (
  input  logic                              clk,
  input  logic                              rst_lck,
  // CPU request
  input  logic [soc_pkg::ADDR_W-1:1]        cpu_adr_i,
  input  logic                              cpu_io_i,
  input  logic [soc_pkg::DATA_W-1:0]        cpu_dat_i,
  input  logic [soc_pkg::SEL_W-1:0]         cpu_sel_i,
  input  logic                              cpu_we_i,
  input  logic                              cpu_cyc_i,
  input  logic                              cpu_stb_i,
  // CPU response
  output logic [soc_pkg::DATA_W-1:0]        cpu_dat_o,
  output logic                              cpu_ack_o,
  // Shared slave request
  output logic [soc_pkg::ADDR_W-1:1]        slv_adr_o,
  output logic                              slv_io_o,
  output logic [soc_pkg::DATA_W-1:0]        slv_dat_o,
  output logic [soc_pkg::SEL_W-1:0]         slv_sel_o,
  output logic                              slv_we_o,
  // Per slave
  output logic [soc_pkg::NUM_SLAVES-1:0]    slv_stb_o,
  input  logic [soc_pkg::NUM_SLAVES-1:0]    slv_ack_i,
  input  logic [soc_pkg::DATA_W-1:0]        rom_dat_i,
  input  logic [soc_pkg::DATA_W-1:0]        vga_dat_i,
  input  logic [soc_pkg::DATA_W-1:0]        uart_dat_i,
  input  logic [soc_pkg::DATA_W-1:0]        timer_dat_i,
  input  logic [soc_pkg::DATA_W-1:0]        ram_dat_i,
  // Interrupts
  input  logic [soc_pkg::NUM_IRQ-1:0]       intv_i,
  input  logic                              inta_i,
  input  logic                              nmia_i,
  output logic                              intr_o,
  output logic [soc_pkg::IID_W-1:0]         iid_o
);
  import soc_pkg::*;

  logic              sys_rst;
  logic [DATA_W-1:0] slv_rdat [NUM_SLAVES];   // Read data by slave index
  logic [DATA_W-1:0] dec_rd_dat;
  logic              dec_ack;
  logic [IID_W-1:0]  iid;

  cpu_bus_if bus ();

  // --------------------------------------------------
  // CPU request into the bundle, fan-out to slaves
  // --------------------------------------------------
  assign bus.adr   = {cpu_io_i, cpu_adr_i};   // Tag on top
  assign bus.dat_w = cpu_dat_i;
  assign bus.sel   = cpu_sel_i;
  assign bus.we    = cpu_we_i;
  assign bus.cyc   = cpu_cyc_i;
  assign bus.stb   = cpu_stb_i;

  assign slv_adr_o = bus.adr.mem.wadr;
  assign slv_io_o  = bus.adr.mem.tag;
  assign slv_dat_o = bus.dat_w;
  assign slv_sel_o = bus.sel;
  assign slv_we_o  = bus.we;

  assign slv_rdat[SLV_ROM]   = rom_dat_i;
  assign slv_rdat[SLV_VGA]   = vga_dat_i;
  assign slv_rdat[SLV_UART]  = uart_dat_i;
  assign slv_rdat[SLV_TIMER] = timer_dat_i;
  assign slv_rdat[SLV_RAM]   = ram_dat_i;

  reset_debounce #(
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
  ) u_reset_debounce (
    .clk       (clk),
    .rst_lck   (rst_lck),
    .sys_rst_o (sys_rst)
  );

  slave_decoder u_slave_decoder (
    .clk       (clk),
    .sys_rst_i (sys_rst),
    .bus       (bus.decoder),
    .slv_stb_o (slv_stb_o),
    .slv_ack_i (slv_ack_i),
    .slv_dat_i (slv_rdat),
    .rd_dat_o  (dec_rd_dat),
    .ack_o     (dec_ack)
  );

  irq_controller u_irq_controller (
    .clk       (clk),
    .sys_rst_i (sys_rst),
    .intv_i    (intv_i),
    .inta_i    (inta_i),
    .intr_o    (intr_o),
    .iid_o     (iid)
  );

  cpu_response_mux u_cpu_response_mux (
    .nmia_i    (nmia_i),
    .inta_i    (inta_i),
    .iid_i     (iid),
    .rd_dat_i  (dec_rd_dat),
    .cpu_dat_o (cpu_dat_o)
  );

  assign cpu_ack_o = dec_ack;
  assign iid_o     = iid;

endmodule

// ==== verif/bus_checker.sv ====
// Bus fabric checker
// Tracks reset, address decode and interrupt rules cycle by cycle,
// compares the DUT outputs and keeps per-test and total counts

`timescale 1ns/1ps

module bus_checker #(
  parameter int unsigned DEBOUNCE_CYCLES = 16
) (
  input logic                                          clk,
  input logic                                          rst_lck,
  input logic [soc_pkg::ADDR_W-1:1]                    cpu_adr_i,
  input logic                                          cpu_io_i,
  input logic [soc_pkg::DATA_W-1:0]                    cpu_dat_i,
  input logic [soc_pkg::SEL_W-1:0]                     cpu_sel_i,
  input logic                                          cpu_we_i,
  input logic                                          cpu_cyc_i,
  input logic                                          cpu_stb_i,
  input logic [soc_pkg::DATA_W-1:0]                    rd_dat_i,   // DUT cpu_dat_o
  input logic                                          ack_i,      // DUT cpu_ack_o
  input logic [soc_pkg::ADDR_W-1:1]                    fan_adr_i,
  input logic                                          fan_io_i,
  input logic [soc_pkg::DATA_W-1:0]                    fan_dat_i,
  input logic [soc_pkg::SEL_W-1:0]                     fan_sel_i,
  input logic                                          fan_we_i,
  input logic [soc_pkg::NUM_SLAVES-1:0]                stb_i,
  input logic [soc_pkg::NUM_SLAVES-1:0]                slv_ack_i,
  input logic [soc_pkg::NUM_SLAVES*soc_pkg::DATA_W-1:0] slv_dat_i, // Words by slave index
  input logic [soc_pkg::NUM_IRQ-1:0]                   intv_i,
  input logic                                          inta_i,
  input logic                                          nmia_i,
  input logic                                          intr_i,
  input logic [soc_pkg::IID_W-1:0]                     iid_i
);
  import soc_pkg::*;

  string              test_name = "none";
  int                 test_errs = 0;
  int                 err_total = 0;
  int                 tests_run = 0;
  int                 tests_failed = 0;
  int                 checks = 0;
  int                 edges = 0;       // DUT state known after two edges
  int                 rel_cnt = 0;     // Cycles since rst_lck release
  logic               exp_rst = 1'b1;
  logic [NUM_IRQ-1:0] prev_intv;
  logic [NUM_IRQ-1:0] rise_q;
  logic [NUM_IRQ-1:0] pend;

  // Slave by byte address and port ranges, -1 for the default slave
  function automatic int expect_slave(input logic io, input logic [19:1] adr);
    logic [19:0] byte_a;
    logic [15:0] port;
    byte_a = {adr, 1'b0};
    port   = {adr[15:1], 1'b0};     // Bits 19:16 ignored in I/O space
    if (!io) begin
      if (byte_a >= 20'hFFF00) return int'(SLV_ROM);
      if (byte_a >= 20'hA0000 && byte_a <= 20'hBFFFF) return int'(SLV_VGA);
      return int'(SLV_RAM);
    end
    if (port >= 16'h03C0 && port <= 16'h03DF) return int'(SLV_VGA);
    if (port >= 16'h03F8 && port <= 16'h03FF) return int'(SLV_UART);
    if (port >= 16'h0040 && port <= 16'h0043) return int'(SLV_TIMER);
    return -1;
  endfunction

  function automatic int lowest(input logic [NUM_IRQ-1:0] v);
    int i;
    i = 0;
    while (i < NUM_IRQ && !v[i]) i++;
    return (i == NUM_IRQ) ? 0 : i;  // Zero when nothing pending
  endfunction

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      test_errs++;
      err_total++;
      $display("Fail %s %s: expected %0h actual %0h", test_name, what, exp, act);
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errs != 0) begin
      tests_failed++;
      $display("%s: %0d mismatches", test_name, test_errs);
    end else begin
      $display("%s: passed", test_name);
    end
  endtask

  task automatic summary();
    $display("Tests run %0d, passed %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, checks, err_total);
  endtask

  // --------------------------------------------------
  // Reference model, updated on the DUT clock edge
  // --------------------------------------------------
  always @(posedge clk) begin
    edges <= edges + 1;
    if (!rst_lck) begin
      rel_cnt <= 0;                                   // Reset held
    end else if (rel_cnt <= int'(DEBOUNCE_CYCLES)) begin
      rel_cnt <= rel_cnt + 1;
    end
    exp_rst <= !rst_lck || (rel_cnt < int'(DEBOUNCE_CYCLES));
    if (exp_rst) begin
      prev_intv <= '0;
      rise_q    <= '0;
      pend      <= '0;
    end else begin
      rise_q    <= intv_i & ~prev_intv;               // Edge seen this clock
      prev_intv <= intv_i;
      if (inta_i && pend != '0) begin
        pend <= (pend & ~(NUM_IRQ'(1) << lowest(pend))) | rise_q;
      end else begin
        pend <= pend | rise_q;
      end
    end
  end

  // --------------------------------------------------
  // Compare on the falling edge, all inputs settled
  // --------------------------------------------------
  always @(negedge clk) begin : sample
    int                  exp_idx;
    logic                active;
    logic                exp_ack;
    logic [NUM_SLAVES-1:0] exp_stb;
    if (edges >= 2) begin
      exp_idx = expect_slave(cpu_io_i, cpu_adr_i);
      active  = cpu_cyc_i && cpu_stb_i && !exp_rst;
      exp_stb = '0;
      if (active && exp_idx >= 0) exp_stb[exp_idx] = 1'b1;
      exp_ack = active && ((exp_idx < 0) ? 1'b1 : slv_ack_i[exp_idx]);
      check_val("strobe", exp_stb, stb_i);
      check_val("ack", exp_ack, ack_i);
      check_val("intr", |pend, intr_i);
      if (pend != '0) check_val("iid", lowest(pend), iid_i);
      check_val("slave adr", cpu_adr_i, fan_adr_i);   // Straight fan-out
      check_val("slave io", cpu_io_i, fan_io_i);
      check_val("slave wdata", cpu_dat_i, fan_dat_i);
      check_val("slave sel", cpu_sel_i, fan_sel_i);
      check_val("slave we", cpu_we_i, fan_we_i);
      if (nmia_i) begin
        check_val("nmi vector", NMI_VECTOR, rd_dat_i);  // Beats inta
      end else if (inta_i) begin
        check_val("irq vector", IRQ_VECTOR_BASE + lowest(pend), rd_dat_i);
      end else if (exp_ack && exp_idx < 0) begin
        check_val("default data", 0, rd_dat_i);
      end else if (exp_ack) begin
        check_val("read data", slv_dat_i[exp_idx*DATA_W +: DATA_W], rd_dat_i);
      end
    end
  end

endmodule

// ==== verif/tb_soc_bus_ctrl.sv ====
// SoC bus control testbench
// Random CPU cycles, slave models with random ack delay, interrupt
// traffic and a cycle watchdog around the DUT and its checker

`timescale 1ns/1ps

module tb_soc_bus_ctrl;
  import soc_pkg::*;

  localparam int DEB     = 16;
  localparam int MAP_N   = 200;   // Read cycles over the map
  localparam int WR_N    = 80;
  localparam int RD_N    = 80;
  localparam int IRQ_N   = 20;
  localparam int VEC_N   = 120;
  localparam int BUS_CYC = 6;     // Ack delay 3, plus drop and idle
  localparam int IRQ_CYC = 24;    // Setup 5, two cycles per inta pulse
  localparam int RST_CYC = 2 * DEB + 16;
  localparam int TIMEOUT_CYC = RST_CYC + (MAP_N + WR_N + RD_N) * BUS_CYC +
                               IRQ_N * IRQ_CYC + VEC_N + 200;

  integer                      seed;
  logic                        clk;
  logic                        rst_lck;
  logic [ADDR_W-1:1]           cpu_adr, slv_adr;
  logic                        cpu_io, slv_io;
  logic [DATA_W-1:0]           cpu_wdat, cpu_rdat, slv_wdat;
  logic [SEL_W-1:0]            cpu_sel, slv_sel;
  logic                        cpu_we, cpu_cyc, cpu_stb, cpu_ack, slv_we;
  logic [NUM_SLAVES-1:0]       slv_stb, slv_ack;
  logic [NUM_SLAVES-1:0]       stb_seen, ack_seen;
  logic [NUM_SLAVES*DATA_W-1:0] slv_words;  // Fixed read word per slave
  logic [NUM_IRQ-1:0]          intv, mask;
  logic                        inta, nmia, intr;
  logic [IID_W-1:0]            iid;
  int                          dly_q [NUM_SLAVES];

  soc_bus_ctrl #(.DEBOUNCE_CYCLES(DEB)) dut (
    .clk(clk), .rst_lck(rst_lck),
    .cpu_adr_i(cpu_adr), .cpu_io_i(cpu_io), .cpu_dat_i(cpu_wdat), .cpu_sel_i(cpu_sel),
    .cpu_we_i(cpu_we), .cpu_cyc_i(cpu_cyc), .cpu_stb_i(cpu_stb),
    .cpu_dat_o(cpu_rdat), .cpu_ack_o(cpu_ack),
    .slv_adr_o(slv_adr), .slv_io_o(slv_io), .slv_dat_o(slv_wdat), .slv_sel_o(slv_sel),
    .slv_we_o(slv_we), .slv_stb_o(slv_stb), .slv_ack_i(slv_ack),
    .rom_dat_i(slv_words[0*DATA_W +: DATA_W]), .vga_dat_i(slv_words[1*DATA_W +: DATA_W]),
    .uart_dat_i(slv_words[2*DATA_W +: DATA_W]), .timer_dat_i(slv_words[3*DATA_W +: DATA_W]),
    .ram_dat_i(slv_words[4*DATA_W +: DATA_W]),
    .intv_i(intv), .inta_i(inta), .nmia_i(nmia), .intr_o(intr), .iid_o(iid)
  );

  bus_checker #(.DEBOUNCE_CYCLES(DEB)) chk (
    .clk(clk), .rst_lck(rst_lck),
    .cpu_adr_i(cpu_adr), .cpu_io_i(cpu_io), .cpu_dat_i(cpu_wdat), .cpu_sel_i(cpu_sel),
    .cpu_we_i(cpu_we), .cpu_cyc_i(cpu_cyc), .cpu_stb_i(cpu_stb),
    .rd_dat_i(cpu_rdat), .ack_i(cpu_ack),
    .fan_adr_i(slv_adr), .fan_io_i(slv_io), .fan_dat_i(slv_wdat), .fan_sel_i(slv_sel),
    .fan_we_i(slv_we), .stb_i(slv_stb), .slv_ack_i(slv_ack), .slv_dat_i(slv_words),
    .intv_i(intv), .inta_i(inta), .nmia_i(nmia), .intr_i(intr), .iid_i(iid)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------------------------------------
  // Slave models, ack after 0 to 3 strobed cycles
  // --------------------------------------------------
  always @(negedge clk) begin
    stb_seen = slv_stb;
    ack_seen = slv_ack;
  end

  always @(posedge clk) begin
    #1;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      if (stb_seen[i] && ack_seen[i]) begin
        dly_q[i] = {$random(seed)} % 4;             // Next transfer delay
      end else if (stb_seen[i] && dly_q[i] != 0) begin
        dly_q[i] = dly_q[i] - 1;                    // Back-pressure
      end
      slv_ack[i] = (dly_q[i] == 0);
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Window edges, {io, byte address}
  function automatic logic [20:0] edge_addr(input int k);
    case (k)
      0:       edge_addr = {1'b0, 20'hFFF00};     // ROM first word
      1:       edge_addr = {1'b0, 20'hFFFFE};
      2:       edge_addr = {1'b0, 20'hFFEFE};     // RAM below ROM
      3:       edge_addr = {1'b0, 20'hA0000};
      4:       edge_addr = {1'b0, 20'hBFFFE};
      5:       edge_addr = {1'b0, 20'h9FFFE};
      6:       edge_addr = {1'b0, 20'hC0000};
      7:       edge_addr = {1'b1, 20'h003C0};
      8:       edge_addr = {1'b1, 20'h003DE};
      9:       edge_addr = {1'b1, 20'h003BE};     // Unmapped I/O
      10:      edge_addr = {1'b1, 20'h003E0};
      11:      edge_addr = {1'b1, 20'h003F8};
      12:      edge_addr = {1'b1, 20'h003FE};
      13:      edge_addr = {1'b1, 20'h003F6};
      14:      edge_addr = {1'b1, 20'h00040};
      15:      edge_addr = {1'b1, 20'h00042};
      16:      edge_addr = {1'b1, 20'h00044};
      default: edge_addr = {1'b1, 20'h0003E};
    endcase
  endfunction

  task automatic rand_addr(output logic io, output logic [19:1] adr);
    logic [20:0] a;
    int unsigned k;
    k = {$random(seed)} % 36;
    if (k < 18) begin
      a = edge_addr(k);
    end else if (k < 27) begin
      a = {1'b0, 20'($random(seed))};
    end else begin
      a = {1'b1, 10'h0, 10'($random(seed))};       // Ports near the windows
    end
    if (a[20]) a[19:16] = 4'($random(seed));        // Not decoded in I/O
    io  = a[20];
    adr = a[19:1];
  endtask

  // One CPU cycle, held until ack
  task automatic run_cycle(input logic we);
    rand_addr(cpu_io, cpu_adr);
    cpu_we   = we;
    cpu_wdat = 16'($random(seed));
    cpu_sel  = 2'($random(seed));
    cpu_cyc  = 1'b1;
    cpu_stb  = 1'b1;
    @(negedge clk);
    while (!cpu_ack) @(negedge clk);
    next_cycle();
    cpu_cyc = 1'b0;
    cpu_stb = 1'b0;
    next_cycle();
  endtask

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= TIMEOUT_CYC) begin
      @(posedge clk);
      cycles++;
    end
    $display("Run stopped after %0d cycles, a wait on ack or intr never ended", cycles);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    seed     = 16;
    rst_lck  = 1'b0;
    cpu_we   = 1'b0;
    cpu_wdat = '0;
    cpu_sel  = '0;
    intv     = '0;
    inta     = 1'b0;
    nmia     = 1'b0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      slv_words[i*DATA_W +: DATA_W] = 16'($random(seed));
      dly_q[i]   = {$random(seed)} % 4;
      slv_ack[i] = (dly_q[i] == 0);
    end
    rand_addr(cpu_io, cpu_adr);
    cpu_cyc = 1'b1;                                 // Request during reset
    cpu_stb = 1'b1;

    chk.begin_test("reset");
    repeat (3) next_cycle();
    rst_lck = 1'b1;
    repeat (DEB - 2) begin
      intv = 8'($random(seed));
      next_cycle();
    end
    rst_lck = 1'b0;                                 // Short glitch
    next_cycle();
    rst_lck = 1'b1;
    repeat (DEB + 2) next_cycle();
    cpu_cyc = 1'b0;
    cpu_stb = 1'b0;
    intv    = '0;
    repeat (2) next_cycle();
    chk.end_test();

    chk.begin_test("address_map");
    repeat (MAP_N) run_cycle(1'b0);
    chk.end_test();

    chk.begin_test("write_fanout");
    repeat (WR_N) run_cycle(1'b1);
    chk.end_test();

    chk.begin_test("read_backpressure");
    repeat (RD_N) run_cycle(1'b0);
    chk.end_test();

    chk.begin_test("irq_priority");
    repeat (IRQ_N) begin
      intv = '0;
      repeat (2) next_cycle();
      mask = 8'($random(seed));
      intv = (mask == '0) ? 8'h80 : mask;
      repeat (3) next_cycle();
      while (intr) begin
        inta = 1'b1;
        next_cycle();
        inta = 1'b0;
        next_cycle();
      end
    end
    chk.end_test();

    chk.begin_test("vector_return");
    repeat (VEC_N) begin
      intv = 8'($random(seed));
      inta = 1'($random(seed));
      nmia = ({$random(seed)} % 4) == 0;
      next_cycle();
    end
    inta = 1'b0;
    nmia = 1'b0;
    next_cycle();
    chk.end_test();

    chk.summary();
    if (chk.err_total == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
design/soc_pkg.sv
design/cpu_bus_if.sv
design/reset_debounce.sv
design/slave_decoder.sv
design/irq_controller.sv
design/cpu_response_mux.sv
design/soc_bus_ctrl.sv
verif/bus_checker.sv
verif/tb_soc_bus_ctrl.sv
